/* compile.f */
logic/display_pkg.sv
logic/camera_start.sv
logic/video_timing_gen.sv
logic/video_pack.sv
logic/hdmi_display.sv
tests/display_checker.sv
tests/display_assert.sv
tests/tb_hdmi_display.sv

/* logic/camera_start.sv */
`timescale 1ns/100ps
`default_nettype none

module camera_start (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire                  i_vsync,
    input  wire display_pkg::rgb565_t i_data,

    output logic                 o_run,
    output display_pkg::rgb565_t o_pix
);

    logic vsync_q;                                  // Latest vsync sample
    logic vsync_qq;                                 // Sample before that

    logic vsync_rise;

    // A rising edge needs a low sample followed by a high sample
    assign vsync_rise = vsync_q & ~vsync_qq;

    // Both samples come out of reset high, so a vsync that is already
    // high when reset is released does not count as an edge
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vsync_q  <= 1'b1;
            vsync_qq <= 1'b1;
        end else begin
            vsync_q  <= i_vsync;
            vsync_qq <= vsync_q;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_run <= 1'b0;
        end else if (vsync_rise) begin
            o_run <= 1'b1;                          // Sticky until the next reset
        end
    end

    // First stage of the colour path
    always_ff @(posedge clk) begin
        o_pix <= i_data;
    end

endmodule : camera_start

`default_nettype wire

/* logic/display_pkg.sv */
`default_nettype none

package display_pkg;

    // 1280x720 horizontal timing in pixel clocks
    localparam int H_SYNC  = 12;
    localparam int H_BP    = 275;
    localparam int H_ACT   = 1280;
    localparam int H_FP    = 325;
    localparam int H_TOTAL = H_SYNC + H_BP + H_ACT + H_FP;  // 1892 clocks per line

    // Vertical timing in lines
    localparam int V_SYNC  = 2;
    localparam int V_BP    = 11;
    localparam int V_ACT   = 720;
    localparam int V_FP    = 7;
    localparam int V_TOTAL = V_SYNC + V_BP + V_ACT + V_FP;  // 740 lines per frame

    localparam int H_ACT_START = H_SYNC + H_BP;             // First active column of a line
    localparam int V_ACT_START = V_SYNC + V_BP;             // First active line of a frame
    localparam int H_ACT_END   = H_ACT_START + H_ACT;       // One past the last active column
    localparam int V_ACT_END   = V_ACT_START + V_ACT;       // One past the last active line

    typedef logic [10:0] pix_x_t;                           // Active column 0..1279
    typedef logic [9:0]  pix_y_t;                           // Active row 0..719
    typedef logic [10:0] h_cnt_t;
    typedef logic [9:0]  v_cnt_t;

    // Camera word is {b[4:0], g[5:0], r[4:0]} from msb to lsb
    typedef logic [15:0] rgb565_t;

    typedef logic [23:0] rgb888_t;                          // {r, g, b}, one byte each

    typedef logic [48:0] pack_t;

    // Bit positions inside pack_t
    localparam int PK_SOF    = 48;
    localparam int PK_VS     = 47;
    localparam int PK_HS     = 46;
    localparam int PK_DE     = 45;
    localparam int PK_RGB_HI = 44;
    localparam int PK_RGB_LO = 21;
    localparam int PK_X_HI   = 20;
    localparam int PK_X_LO   = 10;
    localparam int PK_Y_HI   = 9;
    localparam int PK_Y_LO   = 0;

endpackage : display_pkg

`default_nettype wire

/* logic/hdmi_display.sv */
`timescale 1ns/100ps
`default_nettype none

module hdmi_display (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire                       i_vsync,
    input  wire                       i_href,    // Kept for the camera pinout only
    input  wire display_pkg::rgb565_t i_data,

    output display_pkg::pack_t        o_pack
);

    logic                 run;
    display_pkg::rgb565_t pix;

    logic                 hs;
    logic                 vs;
    logic                 de;
    logic                 sof;
    display_pkg::pix_x_t  x;
    display_pkg::pix_y_t  y;

    camera_start u_camera_start (
        .clk     (clk),
        .rstn    (rstn),
        .i_vsync (i_vsync),
        .i_data  (i_data),
        .o_run   (run),
        .o_pix   (pix)
    );

    video_timing_gen u_video_timing_gen (
        .clk     (clk),
        .rstn    (rstn),
        .i_run   (run),
        .o_hs    (hs),
        .o_vs    (vs),
        .o_de    (de),
        .o_sof   (sof),
        .o_x     (x),
        .o_y     (y)
    );

    video_pack u_video_pack (
        .clk     (clk),
        .rstn    (rstn),
        .i_run   (run),
        .i_pix   (pix),
        .i_hs    (hs),
        .i_vs    (vs),
        .i_de    (de),
        .i_sof   (sof),
        .i_x     (x),
        .i_y     (y),
        .o_pack  (o_pack)
    );

endmodule : hdmi_display

`default_nettype wire

/* logic/video_pack.sv */
`timescale 1ns/100ps
`default_nettype none

module video_pack (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire                       i_run,
    input  wire display_pkg::rgb565_t i_pix,
    input  wire                       i_hs,
    input  wire                       i_vs,
    input  wire                       i_de,
    input  wire                       i_sof,
    input  wire display_pkg::pix_x_t  i_x,
    input  wire display_pkg::pix_y_t  i_y,

    output display_pkg::pack_t        o_pack
);

    display_pkg::rgb565_t pix_d;                    // Matches the registered timing outputs
    display_pkg::rgb888_t rgb;
    display_pkg::pack_t   pack_w;

    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;

    always_ff @(posedge clk) begin
        pix_d <= i_pix;
    end

    // Low bits are zero filled
    assign red   = {pix_d[4:0], 3'b000};
    assign green = {pix_d[10:5], 2'b00};
    assign blue  = {pix_d[15:11], 3'b000};

    // Camera data is meaningless until the first frame sync
    assign rgb = i_run ? {red, green, blue} : '0;

    always_comb begin
        pack_w                                                = '0;
        pack_w[display_pkg::PK_SOF]                           = i_sof;
        pack_w[display_pkg::PK_VS]                            = i_vs;
        pack_w[display_pkg::PK_HS]                            = i_hs;
        pack_w[display_pkg::PK_DE]                            = i_de;
        pack_w[display_pkg::PK_RGB_HI:display_pkg::PK_RGB_LO] = rgb;
        pack_w[display_pkg::PK_X_HI:display_pkg::PK_X_LO]     = i_x;
        pack_w[display_pkg::PK_Y_HI:display_pkg::PK_Y_LO]     = i_y;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_pack <= '0;
        end else begin
            o_pack <= pack_w;
        end
    end

endmodule : video_pack

`default_nettype wire

/* logic/video_timing_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module video_timing_gen (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire                 i_run,

    output logic                o_hs,
    output logic                o_vs,
    output logic                o_de,
    output logic                o_sof,
    output display_pkg::pix_x_t o_x,
    output display_pkg::pix_y_t o_y
);

    localparam display_pkg::h_cnt_t H_LAST  = display_pkg::h_cnt_t'(display_pkg::H_TOTAL - 1);
    localparam display_pkg::v_cnt_t V_LAST  = display_pkg::v_cnt_t'(display_pkg::V_TOTAL - 1);
    localparam display_pkg::h_cnt_t H_START = display_pkg::h_cnt_t'(display_pkg::H_ACT_START);
    localparam display_pkg::v_cnt_t V_START = display_pkg::v_cnt_t'(display_pkg::V_ACT_START);

    logic                run_en;                // Run level delayed by one clock
    display_pkg::h_cnt_t h_cnt;
    display_pkg::v_cnt_t v_cnt;

    logic                h_wrap;
    logic                v_wrap;

    logic                hs_w;
    logic                vs_w;
    logic                h_act;
    logic                v_act;
    logic                de_w;
    logic                sof_w;
    display_pkg::h_cnt_t h_rel;
    display_pkg::v_cnt_t v_rel;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            run_en <= 1'b0;
        end else begin
            run_en <= i_run;
        end
    end

    assign h_wrap = (h_cnt == H_LAST);
    assign v_wrap = (v_cnt == V_LAST);

    // The counters rest at (0,0) until the run starts and then never stop
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            h_cnt <= '0;
        end else if (!run_en) begin
            h_cnt <= '0;
        end else if (h_wrap) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            v_cnt <= '0;
        end else if (!run_en) begin
            v_cnt <= '0;
        end else if (h_wrap) begin
            if (v_wrap) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;              // Next line
            end
        end
    end

    assign hs_w  = (h_cnt < display_pkg::H_SYNC);
    assign vs_w  = (v_cnt < display_pkg::V_SYNC);

    assign h_act = (h_cnt >= display_pkg::H_ACT_START) && (h_cnt < display_pkg::H_ACT_END);
    assign v_act = (v_cnt >= display_pkg::V_ACT_START) && (v_cnt < display_pkg::V_ACT_END);
    assign de_w  = h_act & v_act;

    // First active pixel of the frame
    assign sof_w = (h_cnt == H_START) && (v_cnt == V_START);

    assign h_rel = h_cnt - H_START;
    assign v_rel = v_cnt - V_START;

    // Outputs lag the counters by one clock and stay low before the run
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_hs  <= 1'b0;
            o_vs  <= 1'b0;
            o_de  <= 1'b0;
            o_sof <= 1'b0;
            o_x   <= '0;
            o_y   <= '0;
        end else begin
            o_hs  <= run_en & hs_w;
            o_vs  <= run_en & vs_w;
            o_de  <= run_en & de_w;
            o_sof <= run_en & sof_w;
            if (run_en && de_w) begin
                o_x <= display_pkg::pix_x_t'(h_rel);
                o_y <= display_pkg::pix_y_t'(v_rel);
            end else begin
                o_x <= '0;                          // Coordinates read zero in blanking
                o_y <= '0;
            end
        end
    end

endmodule : video_timing_gen

`default_nettype wire

/* tests/display_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module display_assert (
    input wire clk,
    input wire rstn,
    input wire i_run,
    input wire i_hs,
    input wire i_de,
    input wire i_sof
);

    hs_outside_de: assert property (@(posedge clk) disable iff (!rstn) !(i_hs && i_de))
        else $error("hsync is high while data enable is high");

    sof_inside_de: assert property (@(posedge clk) disable iff (!rstn) i_sof |-> i_de)
        else $error("start of frame without data enable");

    // The run enable is sticky once the camera has started
    run_never_falls: assert property (@(posedge clk) disable iff (!rstn) !$fell(i_run))
        else $error("run enable dropped while out of reset");

endmodule : display_assert

bind video_timing_gen display_assert u_display_assert (
    .clk   (clk),
    .rstn  (rstn),
    .i_run (i_run),
    .i_hs  (o_hs),
    .i_de  (o_de),
    .i_sof (o_sof)
);

`default_nettype wire

/* tests/display_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module display_checker (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire                       i_vsync,
    input  wire                       i_exp_valid,
    input  wire display_pkg::rgb888_t i_exp_rgb,
    input  wire display_pkg::pack_t   i_pack,

    output logic                      o_done,
    output int                        o_checks,
    output int                        o_errors
);

    localparam int T_START  = 0;
    localparam int T_HORZ   = 1;
    localparam int T_COORD  = 2;
    localparam int T_COLOUR = 3;
    localparam int T_FRAME  = 4;

    localparam int RUN_CYCLES = 2 * display_pkg::V_TOTAL * display_pkg::H_TOTAL;

    int                   edge_n;
    int                   start_edge;                 // Edge that sampled the first vsync rise
    int                   t;
    int                   h;
    int                   v;
    int                   exp_x;
    int                   exp_y;
    int                   colour_checks;
    int                   test_errs [5];
    logic                 vs_prev;
    logic                 running;
    logic                 colour_on;
    logic                 exp_hs;
    logic                 exp_vs;
    logic                 exp_de;
    logic                 exp_sof;
    logic [2:0]           valid_hist;
    display_pkg::rgb888_t rgb_hist [3];

    task automatic compare(input int test_id, input string name,
                           input logic [63:0] exp_v, input logic [63:0] act_v);
        o_checks++;
        if (exp_v !== act_v) begin
            o_errors++;
            test_errs[test_id]++;
            if (o_errors <= 20) begin
                $display("[ERROR] %s expected 0x%h actual 0x%h at edge %0d",
                         name, exp_v, act_v, edge_n);
            end
        end
    endtask

    task automatic report_test(input int test_id, input string name);
        $display("test %-12s %s (%0d errors)", name,
                 (test_errs[test_id] == 0) ? "ok" : "failed", test_errs[test_id]);
    endtask

    initial begin
        o_done        = 1'b0;
        o_checks      = 0;
        o_errors      = 0;
        edge_n        = 0;
        start_edge    = -1;
        vs_prev       = 1'b1;
        valid_hist    = '0;
        colour_checks = 0;
        for (int i = 0; i < 5; i++) begin
            test_errs[i] = 0;
        end
    end

    always @(posedge clk) begin
        if (!rstn) begin
            vs_prev    = 1'b1;                          // A vsync high out of reset is no edge
            start_edge = -1;
            compare(T_START, "o_pack", 64'd0, 64'(i_pack));
        end else if (!o_done) begin
            running   = (start_edge >= 0) && (edge_n >= start_edge + 5);
            colour_on = (start_edge >= 0) && (edge_n >= start_edge + 3);
            t = 0;
            if (running) begin
                t      = edge_n - start_edge - 5;
                h      = t % display_pkg::H_TOTAL;
                v      = (t / display_pkg::H_TOTAL) % display_pkg::V_TOTAL;
                exp_hs = (h < display_pkg::H_SYNC);
                exp_vs = (v < display_pkg::V_SYNC);
                exp_de = (h >= display_pkg::H_ACT_START)
                      && (h < display_pkg::H_ACT_START + display_pkg::H_ACT)
                      && (v >= display_pkg::V_ACT_START)
                      && (v < display_pkg::V_ACT_START + display_pkg::V_ACT);
                exp_x   = exp_de ? h - display_pkg::H_ACT_START : 0;
                exp_y   = exp_de ? v - display_pkg::V_ACT_START : 0;
                exp_sof = exp_de && (exp_x == 0) && (exp_y == 0);
            end else begin
                exp_hs  = 1'b0;
                exp_vs  = 1'b0;
                exp_de  = 1'b0;
                exp_sof = 1'b0;
                exp_x   = 0;
                exp_y   = 0;
            end

            compare(running ? T_HORZ : T_START, "hs", 64'(exp_hs),
                    64'(i_pack[display_pkg::PK_HS]));
            compare(running ? T_HORZ : T_START, "de", 64'(exp_de),
                    64'(i_pack[display_pkg::PK_DE]));
            compare(running ? T_FRAME : T_START, "vs", 64'(exp_vs),
                    64'(i_pack[display_pkg::PK_VS]));
            compare(running ? T_FRAME : T_START, "sof", 64'(exp_sof),
                    64'(i_pack[display_pkg::PK_SOF]));
            compare(running ? T_COORD : T_START, "x", 64'(exp_x),
                    64'(i_pack[display_pkg::PK_X_HI:display_pkg::PK_X_LO]));
            compare(running ? T_COORD : T_START, "y", 64'(exp_y),
                    64'(i_pack[display_pkg::PK_Y_HI:display_pkg::PK_Y_LO]));

            if (!colour_on) begin
                compare(T_START, "rgb", 64'd0,
                        64'(i_pack[display_pkg::PK_RGB_HI:display_pkg::PK_RGB_LO]));
            end else if (exp_de && valid_hist[2]) begin
                colour_checks++;
                compare(T_COLOUR, "rgb", 64'(rgb_hist[2]),
                        64'(i_pack[display_pkg::PK_RGB_HI:display_pkg::PK_RGB_LO]));
            end

            if ((start_edge >= 0) && (edge_n == start_edge + 5)) begin
                report_test(T_START, "start");
            end

            if (running && (t == RUN_CYCLES - 1)) begin
                if (colour_checks == 0) begin
                    $display("Colour test never saw a table word inside the active region");
                    o_errors++;
                    test_errs[T_COLOUR]++;
                end
                report_test(T_HORZ, "horizontal");
                report_test(T_COORD, "coordinates");
                report_test(T_COLOUR, "colour");
                report_test(T_FRAME, "frame");
                o_done = 1'b1;
            end

            // Only the first rise counts, later ones must not move the timing
            if ((start_edge < 0) && i_vsync && !vs_prev) begin
                start_edge = edge_n;
            end
            vs_prev = i_vsync;
        end

        // Index 2 holds what was sampled three edges ago
        valid_hist  = {valid_hist[1:0], i_exp_valid};
        rgb_hist[2] = rgb_hist[1];
        rgb_hist[1] = rgb_hist[0];
        rgb_hist[0] = i_exp_rgb;
        edge_n++;
    end

endmodule : display_checker

`default_nettype wire

/* tests/tb_hdmi_display.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_hdmi_display;

    localparam int TABLE_LEN = 8;
    localparam int STIM_CYCLES = display_pkg::H_ACT / 2;
    localparam longint WATCHDOG_CYCLES = 10 + 200
        + 2 * display_pkg::V_TOTAL * display_pkg::H_TOTAL
        + TABLE_LEN * display_pkg::H_TOTAL;

    logic                 clk;
    logic                 rstn;
    logic                 i_vsync;
    logic                 i_href;
    display_pkg::rgb565_t i_data;
    display_pkg::pack_t   o_pack;

    logic                 exp_valid;
    display_pkg::rgb888_t exp_rgb;
    logic                 done;
    int                   checks;
    int                   errors;
    integer               seed;
    int                   target_y;

    // Camera words and their expanded colour, red then green then blue
    display_pkg::rgb565_t stim_pix [TABLE_LEN] = '{
        16'h0000, 16'hFFFF, 16'h001F, 16'h07E0,
        16'hF800, 16'h1234, 16'hABCD, 16'h5A5A
    };
    display_pkg::rgb888_t stim_rgb [TABLE_LEN] = '{
        24'h000000, 24'hF8FCF8, 24'hF80000, 24'h00FC00,
        24'h0000F8, 24'hA04410, 24'h6878A8, 24'hD04858
    };

    hdmi_display u_dut (
        .clk     (clk),
        .rstn    (rstn),
        .i_vsync (i_vsync),
        .i_href  (i_href),
        .i_data  (i_data),
        .o_pack  (o_pack)
    );

    display_checker u_checker (
        .clk         (clk),
        .rstn        (rstn),
        .i_vsync     (i_vsync),
        .i_exp_valid (exp_valid),
        .i_exp_rgb   (exp_rgb),
        .i_pack      (o_pack),
        .o_done      (done),
        .o_checks    (checks),
        .o_errors    (errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        seed = 73;
    end

    always @(posedge clk) begin
        i_href <= 1'($random(seed));                    // Ignored by the DUT
    end

    initial begin
        rstn      = 1'b0;
        i_vsync   = 1'b1;                               // High from reset, must not start the run
        i_href    = 1'b0;
        i_data    = 16'hFFFF;                           // Full white that must stay blanked
        exp_valid = 1'b0;
        exp_rgb   = '0;
        target_y  = 0;

        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        repeat (20) @(posedge clk);
        i_vsync <= 1'b0;
        repeat (20) @(posedge clk);
        i_vsync <= 1'b1;                                // The one rise that counts
        repeat (40) @(posedge clk);
        i_vsync <= 1'b0;
        repeat (30) @(posedge clk);
        i_vsync <= 1'b1;
        repeat (30) @(posedge clk);
        i_vsync <= 1'b0;

        for (int i = 0; i < TABLE_LEN; i++) begin
            target_y = 100 + i * 40;
            do begin
                @(posedge clk);
            end while (!(o_pack[display_pkg::PK_DE]
                         && (o_pack[display_pkg::PK_Y_HI:display_pkg::PK_Y_LO] == target_y)));
            i_data    <= stim_pix[i];
            exp_rgb   <= stim_rgb[i];
            exp_valid <= 1'b1;
            repeat (STIM_CYCLES) @(posedge clk);        // Word ends while the line is still active
            exp_valid <= 1'b0;
            i_data    <= display_pkg::rgb565_t'($random(seed));
        end

        wait (done);
        @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 8);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule : tb_hdmi_display

`default_nettype wire
